//--- project.f
source/tinker_pkg.sv
source/core_if.sv
source/instruction_sequencer.sv
source/instruction_decode.sv
source/register_file.sv
source/execute_unit.sv
source/result_writeback.sv
source/tinker_core.sv
sim/clock_gen.sv
sim/tinker_assertions.sv
sim/tb_tinker_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_tinker_core -Mdir obj_dir -o tb_tinker_core

if ./obj_dir/tb_tinker_core | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- sim/tb_tinker_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tinker_core;
    import tinker_pkg::*;

    localparam word_t RESET_PC    = 64'h2000;
    localparam int    NUM_TESTS   = 5;
    localparam int    MAX_PROG    = 40;   // Longest program, in instructions
    localparam int    WATCHDOG_NS = 2 * NUM_TESTS * MAX_PROG * 3 * 4 + 400;

    wire    clk;
    wire    init_reset;
    wire    reset;
    logic   reset_pulse = 1'b0;
    instr_t fetch_word  = '0;
    word_t  mem_rdata   = '0;
    word_t  fetch_addr, mem_addr, mem_wdata;
    logic   mem_read, mem_write, hlt;

    instr_t      imem [word_t];
    word_t       dmem [word_t];
    word_t       fetch_log[$], store_addr_log[$], store_data_log[$], load_addr_log[$];
    word_t       exp_fetch[$], exp_addr[$], exp_data[$], exp_load[$];
    word_t       next_addr;
    int          phase_count = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] rng = 32'he025e304;

    assign reset = init_reset | reset_pulse;

    clock_gen clk0 (.clk(clk), .reset(init_reset));

    tinker_core #(.RESET_PC(RESET_PC)) dut0 (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fetch_word (fetch_word),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_rdata  (mem_rdata),
        .hlt        (hlt)
    );

    bind tinker_core tinker_assertions chk0 (
        .clk       (clk),
        .reset     (reset),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .hlt       (hlt)
    );

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Memories answer on the falling edge, fetch log follows the 3-cycle rhythm
    always @(negedge clk) begin
        fetch_word <= imem.exists(fetch_addr) ? imem[fetch_addr] : {OP_PRIV, 27'd0};
        if (mem_read) begin
            mem_rdata <= dmem.exists(mem_addr) ? dmem[mem_addr] : '0;
            load_addr_log.push_back(mem_addr);
        end
        if (mem_write) begin
            dmem[mem_addr] = mem_wdata;
            store_addr_log.push_back(mem_addr);
            store_data_log.push_back(mem_wdata);
        end
        if (reset) begin
            phase_count = 0;
        end else if (!hlt) begin
            phase_count = (phase_count + 1) % 3;
            if (phase_count == 0) begin
                fetch_log.push_back(fetch_addr);
            end else if (fetch_log.size() > 0) begin
                compare_value("fetch_addr", fetch_addr, fetch_log[$]);   // Stable mid-instruction
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic instr_t encode(input logic [4:0] op, input int rd, input int rs,
                                      input int rt, input logic [11:0] lit);
        return {op, rd[4:0], rs[4:0], rt[4:0], lit};
    endfunction

    task automatic new_program();
        imem.delete();
        dmem.delete();
        exp_fetch.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_load.delete();
        next_addr = RESET_PC;
    endtask

    // Instructions are fetched in the order they are placed
    task automatic place(input instr_t instr);
        imem[next_addr] = instr;
        exp_fetch.push_back(next_addr);
        next_addr += INSTR_BYTES;
    endtask

    // Store through r30, which stays zero
    task automatic append_store(input int src, input logic [11:0] addr, input word_t data);
        place(encode(OP_MOV_STR, 30, src, 0, addr));
        exp_addr.push_back(word_t'(addr));
        exp_data.push_back(data);
    endtask

    task automatic run_program();
        place(encode(OP_PRIV, 0, 0, 0, 12'd0));
        @(negedge clk);
        reset_pulse <= 1'b1;
        repeat (3) @(negedge clk);
        compare_value("hlt", word_t'(hlt), 64'd0);
        compare_value("mem_read", word_t'(mem_read), 64'd0);
        compare_value("mem_write", word_t'(mem_write), 64'd0);
        compare_value("fetch_addr", fetch_addr, RESET_PC);
        reset_pulse <= 1'b0;
        fetch_log.delete();
        store_addr_log.delete();
        store_data_log.delete();
        load_addr_log.delete();
        fetch_log.push_back(fetch_addr);   // First fetch comes as reset is released
        while (!hlt) @(negedge clk);
        assert (fetch_log.size() == exp_fetch.size()) else begin
            errors++;
            $display("Fetched %0d instructions, expected %0d", fetch_log.size(),
                     exp_fetch.size());
        end
        for (int i = 0; i < fetch_log.size() && i < exp_fetch.size(); i++) begin
            compare_value("fetch_addr", fetch_log[i], exp_fetch[i]);
        end
        assert (store_addr_log.size() == exp_addr.size()) else begin
            errors++;
            $display("Saw %0d stores, expected %0d", store_addr_log.size(), exp_addr.size());
        end
        for (int i = 0; i < store_addr_log.size() && i < exp_addr.size(); i++) begin
            compare_value("mem_addr", store_addr_log[i], exp_addr[i]);
            compare_value("mem_wdata", store_data_log[i], exp_data[i]);
        end
        assert (load_addr_log.size() == exp_load.size()) else begin
            errors++;
            $display("Saw %0d loads, expected %0d", load_addr_log.size(), exp_load.size());
        end
        for (int i = 0; i < load_addr_log.size() && i < exp_load.size(); i++) begin
            compare_value("mem_addr", load_addr_log[i], exp_load[i]);
        end
    endtask

    task automatic try_reg_op(input logic [4:0] op, input int rt, input word_t exp);
        place(encode(op, 3, 1, rt, 12'd0));
        append_store(3, 12'(exp_addr.size()), exp);
    endtask

    task automatic try_imm_op(input logic [4:0] op, input word_t a, input word_t lit,
                              input word_t exp);
        place(encode(OP_XOR, 6, 6, 6, 12'd0));   // Clear r6 so mov_lit leaves no upper bits
        place(encode(OP_MOV_LIT, 6, 0, 0, a[11:0]));
        place(encode(op, 6, 0, 0, lit[11:0]));
        append_store(6, 12'(exp_addr.size()), exp);
    endtask

    task automatic fetch_stepping();
        new_program();
        repeat (4) place(encode(5'h14, 1, 2, 3, 12'h0ff));   // Unused opcode
        run_program();
    endtask

    task automatic alu_operations();
        word_t a, b, s;
        a = word_t'(next_random() & 32'hfff);
        b = word_t'(next_random() & 32'hfff);
        s = word_t'(next_random() & 32'h3f);
        new_program();
        place(encode(OP_MOV_LIT, 1, 0, 0, a[11:0]));
        place(encode(OP_MOV_LIT, 2, 0, 0, b[11:0]));
        place(encode(OP_MOV_LIT, 5, 0, 0, s[11:0]));
        try_reg_op(OP_ADD, 2, a + b);
        try_reg_op(OP_SUB, 2, a - b);
        try_reg_op(OP_MUL, 2, a * b);
        try_reg_op(OP_AND, 2, a & b);
        try_reg_op(OP_OR, 2, a | b);
        try_reg_op(OP_XOR, 2, a ^ b);
        try_reg_op(OP_NOT, 2, ~a);
        try_reg_op(OP_SHFTR, 5, a >> s);
        try_reg_op(OP_SHFTL, 5, a << s);
        try_imm_op(OP_ADDI, a, b, a + b);
        try_imm_op(OP_SUBI, a, b, a - b);
        try_imm_op(OP_SHFTRI, a, s, a >> s);
        try_imm_op(OP_SHFTLI, a, s, a << s);
        run_program();
    endtask

    task automatic register_moves();
        word_t x, c, shifted, merged;
        x       = word_t'((next_random() & 32'hfff) | 32'h1);
        c       = word_t'(next_random() & 32'hfff);
        shifted = x << 20;
        merged  = {shifted[63:12], c[11:0]};
        new_program();
        place(encode(OP_MOV_LIT, 7, 0, 0, x[11:0]));
        place(encode(OP_SHFTLI, 7, 0, 0, 12'd20));
        place(encode(OP_MOV_LIT, 7, 0, 0, c[11:0]));   // Upper bits of r7 kept
        place(encode(OP_MOV_REG, 8, 7, 0, 12'd0));
        append_store(8, 12'h105, merged);
        place(encode(OP_MOV_LIT, 10, 0, 0, 12'h100));
        place(encode(OP_MOV_MEM, 9, 10, 0, 12'd5));    // Loads back from 105h
        exp_load.push_back(64'h105);
        append_store(9, 12'h106, merged);
        run_program();
    endtask

    task automatic branch_paths();
        new_program();
        place(encode(OP_MOV_LIT, 1, 0, 0, 12'h800));
        place(encode(OP_SHFTLI, 1, 0, 0, 12'd2));
        place(encode(OP_ADDI, 1, 0, 0, 12'h100));      // r1 = 2100h
        place(encode(OP_BR, 1, 0, 0, 12'd0));
        next_addr = 64'h2100;
        place(encode(OP_MOV_LIT, 2, 0, 0, 12'h080));
        place(encode(OP_BRR, 2, 0, 0, 12'd0));
        next_addr = 64'h2104 + 64'h80;
        place(encode(OP_BRRI, 0, 0, 0, 12'hfc0));      // Back by 40h
        next_addr = 64'h2184 - 64'h40;
        place(encode(OP_BRNZ, 1, 3, 0, 12'd0));        // r3 still zero
        place(encode(OP_MOV_LIT, 3, 0, 0, 12'd5));
        place(encode(OP_MOV_REG, 4, 1, 0, 12'd0));
        place(encode(OP_ADDI, 4, 0, 0, 12'h200));      // r4 = 2300h
        place(encode(OP_BRNZ, 4, 3, 0, 12'd0));
        next_addr = 64'h2300;
        place(encode(OP_BRGT, 1, 3, 2, 12'd0));        // 5 > 80h fails
        place(encode(OP_MOV_REG, 5, 4, 0, 12'd0));
        place(encode(OP_ADDI, 5, 0, 0, 12'h100));      // r5 = 2400h
        place(encode(OP_BRGT, 5, 2, 3, 12'd0));
        next_addr = 64'h2400;
        run_program();
    endtask

    task automatic halt_and_unknown();
        word_t v, halt_pc;
        int    stores;
        v = word_t'((next_random() & 32'hfff) | 32'h1);
        new_program();
        place(encode(OP_MOV_LIT, 1, 0, 0, v[11:0]));
        place(encode(5'h1d, 1, 1, 1, 12'hfff));        // Must leave r1 alone
        append_store(1, 12'd0, v);
        run_program();
        halt_pc = exp_fetch[$] + INSTR_BYTES;
        stores  = store_addr_log.size();
        repeat (8) begin
            @(negedge clk);
            compare_value("hlt", word_t'(hlt), 64'd1);
            compare_value("fetch_addr", fetch_addr, halt_pc);
            compare_value("mem_read", word_t'(mem_read), 64'd0);
        end
        assert (store_addr_log.size() == stores) else begin
            errors++;
            $display("Store issued after the core halted");
        end
    endtask

    initial begin
        wait (!init_reset);
        @(negedge clk);
        fetch_stepping();
        alu_operations();
        register_moves();
        branch_paths();
        halt_and_unknown();
        $display("checks: %0d, failed checks: %0d, assertion failures: %0d",
                 checks, errors, dut0.chk0.fails);
        if (errors == 0 && dut0.chk0.fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- sim/tinker_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module tinker_assertions (
    input wire clk,
    input wire reset,
    input wire mem_read,
    input wire mem_write,
    input wire hlt
);
    int unsigned fails = 0;   // Read by the testbench for its closing report

    strobe_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(mem_read && mem_write)
    ) else begin
        fails++;
        $error("mem_read and mem_write were high in the same cycle");
    end

    // Halt is sticky until reset
    halt_sticky: assert property (
        @(posedge clk) disable iff (reset) hlt |=> hlt
    ) else begin
        fails++;
        $error("hlt fell without a reset");
    end

    halted_quiet: assert property (
        @(posedge clk) disable iff (reset) hlt |-> !(mem_read || mem_write)
    ) else begin
        fails++;
        $error("memory strobe while the core was halted");
    end
endmodule

`default_nettype wire

//--- sim/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD = 2   // 4 ns clock
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Held for 3 cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end
endmodule

`default_nettype wire

//--- source/tinker_core.sv
`timescale 1ns/10ps
`default_nettype none

module tinker_core #(
    parameter tinker_pkg::word_t RESET_PC = 64'h2000
) (
    input  wire                  clk,
    input  wire                  reset,
    output tinker_pkg::word_t    fetch_addr,
    input  tinker_pkg::instr_t   fetch_word,
    output tinker_pkg::word_t    mem_addr,
    output tinker_pkg::word_t    mem_wdata,
    output logic                 mem_read,
    output logic                 mem_write,
    input  tinker_pkg::word_t    mem_rdata,
    output logic                 hlt
);
    import tinker_pkg::*;

    phase_t phase;
    word_t  next_pc;
    logic   halt_req;
    word_t  rs_value, rt_value, rd_value;
    logic   wr_en;
    word_t  wr_data;

    decode_if dec ();
    exec_if   ex ();

    instruction_sequencer #(.RESET_PC(RESET_PC)) seq0 (
        .clk        (clk),
        .reset      (reset),
        .next_pc    (next_pc),
        .halt_req   (halt_req),
        .phase      (phase),
        .fetch_addr (fetch_addr),
        .hlt        (hlt)
    );

    instruction_decode dec0 (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .fetch_word (fetch_word),
        .dec        (dec.source)
    );

    register_file rf0 (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec.reader),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .rd_value (rd_value)
    );

    // PC of the current instruction is the fetch address until the result phase ends
    execute_unit exe0 (
        .clk      (clk),
        .reset    (reset),
        .phase    (phase),
        .pc       (fetch_addr),
        .dec      (dec.reader),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .rd_value (rd_value),
        .ex       (ex.source),
        .halt_req (halt_req)
    );

    result_writeback wb0 (
        .phase     (phase),
        .dec       (dec.reader),
        .ex        (ex.sink),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .next_pc   (next_pc)
    );
endmodule

`default_nettype wire

//--- source/result_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module result_writeback (
    input  tinker_pkg::phase_t  phase,
    decode_if.reader            dec,
    exec_if.sink                ex,
    input  tinker_pkg::word_t   mem_rdata,
    output tinker_pkg::word_t   mem_addr,
    output tinker_pkg::word_t   mem_wdata,
    output logic                mem_read,
    output logic                mem_write,
    output logic                wr_en,
    output tinker_pkg::word_t   wr_data,
    output tinker_pkg::word_t   next_pc
);
    import tinker_pkg::*;

    logic in_result;

    assign in_result = (phase == PH_RESULT);

    // Strobes last exactly the result cycle
    assign mem_read  = in_result && dec.loads;
    assign mem_write = in_result && dec.stores;
    assign wr_en     = in_result && dec.writes_reg;

    assign mem_addr  = ex.mem_address;
    assign mem_wdata = ex.store_data;

    // Load data comes straight from the memory answer
    assign wr_data = dec.loads ? mem_rdata : ex.result;

    assign next_pc = ex.next_pc;   // Sequencer loads it at the end of the result phase
endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  wire                 clk,
    input  wire                 reset,
    input  tinker_pkg::phase_t  phase,
    input  tinker_pkg::word_t   pc,
    decode_if.reader            dec,
    input  tinker_pkg::word_t   rs_value,
    input  tinker_pkg::word_t   rt_value,
    input  tinker_pkg::word_t   rd_value,
    exec_if.source              ex,
    output logic                halt_req
);
    import tinker_pkg::*;

    word_t operand;
    word_t lit_sext;
    word_t seq_pc;
    word_t result_d;
    word_t address_d;
    word_t store_d;
    word_t next_pc_d;

    assign operand  = dec.alu_op_uses_literal ? dec.literal : rt_value;
    assign lit_sext = {{(WORD_W-LIT_W){dec.literal[LIT_W-1]}}, dec.literal[LIT_W-1:0]};
    assign seq_pc   = pc + INSTR_BYTES;

    assign halt_req = (dec.opcode == OP_PRIV);

    always_comb begin
        result_d  = '0;
        address_d = '0;
        store_d   = '0;
        next_pc_d = seq_pc;   // Fall-through for everything but taken branches
        case (dec.opcode)
            OP_ADD, OP_ADDI:     result_d = rs_value + operand;
            OP_SUB, OP_SUBI:     result_d = rs_value - operand;
            OP_MUL:              result_d = rs_value * operand;
            OP_AND:              result_d = rs_value & operand;
            OP_OR:               result_d = rs_value | operand;
            OP_XOR:              result_d = rs_value ^ operand;
            OP_NOT:              result_d = ~rs_value;
            OP_SHFTR, OP_SHFTRI: result_d = rs_value >> operand;
            OP_SHFTL, OP_SHFTLI: result_d = rs_value << operand;
            OP_MOV_REG:          result_d = rs_value;
            OP_MOV_LIT:          result_d = {rd_value[WORD_W-1:LIT_W], operand[LIT_W-1:0]};
            OP_MOV_MEM:          address_d = rs_value + dec.literal;
            OP_MOV_STR: begin
                address_d = rd_value + dec.literal;
                store_d   = rs_value;
            end
            OP_BR:               next_pc_d = rd_value;
            OP_BRR:              next_pc_d = pc + rd_value;
            OP_BRRI:             next_pc_d = pc + lit_sext;
            OP_BRNZ: begin
                if (rs_value != '0) begin
                    next_pc_d = rd_value;
                end
            end
            OP_BRGT: begin
                if (rs_value > rt_value) begin   // Unsigned compare
                    next_pc_d = rd_value;
                end
            end
            default: ;
        endcase
    end

    // Captured once per instruction, held through the result phase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex.result      <= '0;
            ex.mem_address <= '0;
            ex.store_data  <= '0;
            ex.next_pc     <= '0;
        end else if (phase == PH_EXECUTE) begin
            ex.result      <= result_d;
            ex.mem_address <= address_d;
            ex.store_data  <= store_d;
            ex.next_pc     <= next_pc_d;
        end
    end
endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  wire                clk,
    input  wire                reset,
    decode_if.reader           dec,
    input  wire                wr_en,
    input  tinker_pkg::word_t  wr_data,
    output tinker_pkg::word_t  rs_value,
    output tinker_pkg::word_t  rt_value,
    output tinker_pkg::word_t  rd_value
);
    import tinker_pkg::*;

    word_t regs [NUM_REGS];

    // Asynchronous reads
    assign rs_value = regs[dec.rs];
    assign rt_value = regs[dec.rt];
    assign rd_value = regs[dec.rd];   // Base for stores and branch targets

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[dec.rd] <= wr_data;
        end
    end
endmodule

`default_nettype wire

//--- source/instruction_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instruction_decode (
    input  wire                 clk,
    input  wire                 reset,
    input  tinker_pkg::phase_t  phase,
    input  tinker_pkg::instr_t  fetch_word,
    decode_if.source            dec
);
    import tinker_pkg::*;

    opcode_t  op_in;
    reg_idx_t rs_in;
    logic     uses_lit_in;
    logic     writes_reg_in;

    // Unknown encodings fall through to the default branches below
    assign op_in = opcode_t'(fetch_word[31:27]);

    always_comb begin
        rs_in         = fetch_word[21:17];
        uses_lit_in   = 1'b0;
        writes_reg_in = 1'b0;
        case (op_in)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOV_LIT: begin
                rs_in         = fetch_word[26:22];   // Source is rd itself
                uses_lit_in   = 1'b1;
                writes_reg_in = 1'b1;
            end
            OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_SHFTR, OP_SHFTL, OP_MOV_REG, OP_MOV_MEM: begin
                writes_reg_in = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec.opcode              <= OP_AND;
            dec.rd                  <= '0;
            dec.rs                  <= '0;
            dec.rt                  <= '0;
            dec.literal             <= '0;
            dec.alu_op_uses_literal <= 1'b0;
            dec.writes_reg          <= 1'b0;
            dec.loads               <= 1'b0;
            dec.stores              <= 1'b0;
        end else if (phase == PH_FETCH) begin
            dec.opcode              <= op_in;
            dec.rd                  <= fetch_word[26:22];
            dec.rs                  <= rs_in;
            dec.rt                  <= fetch_word[16:12];
            dec.literal             <= {{(WORD_W-LIT_W){1'b0}}, fetch_word[LIT_W-1:0]};
            dec.alu_op_uses_literal <= uses_lit_in;
            dec.writes_reg          <= writes_reg_in;
            dec.loads               <= (op_in == OP_MOV_MEM);
            dec.stores              <= (op_in == OP_MOV_STR);
        end
    end
endmodule

`default_nettype wire

//--- source/instruction_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module instruction_sequencer #(
    parameter tinker_pkg::word_t RESET_PC = 64'h2000
) (
    input  wire                 clk,
    input  wire                 reset,
    input  tinker_pkg::word_t   next_pc,
    input  wire                 halt_req,
    output tinker_pkg::phase_t  phase,
    output tinker_pkg::word_t   fetch_addr,
    output logic                hlt
);
    import tinker_pkg::*;

    word_t pc;

    assign fetch_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= RESET_PC;
            phase <= PH_FETCH;
            hlt   <= 1'b0;
        end else if (!hlt) begin   // Halted core sits in fetch
            case (phase)
                PH_FETCH:   phase <= PH_EXECUTE;
                PH_EXECUTE: phase <= PH_RESULT;
                PH_RESULT: begin
                    phase <= PH_FETCH;
                    pc    <= next_pc;
                    if (halt_req) begin
                        hlt <= 1'b1;   // Sticky until reset
                    end
                end
                default:    phase <= PH_FETCH;
            endcase
        end
    end
endmodule

`default_nettype wire

//--- source/core_if.sv
`timescale 1ns/10ps
`default_nettype none

// Decoded instruction fields and control flags
interface decode_if;
    import tinker_pkg::*;

    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    literal;              // Zero-extended
    logic     alu_op_uses_literal;
    logic     writes_reg;
    logic     loads;
    logic     stores;

    modport source (output opcode, rd, rs, rt, literal, alu_op_uses_literal,
                    writes_reg, loads, stores);
    modport reader (input opcode, rd, rs, rt, literal, alu_op_uses_literal,
                    writes_reg, loads, stores);
endinterface

// Registered execute results
interface exec_if;
    import tinker_pkg::*;

    word_t result;
    word_t mem_address;
    word_t store_data;
    word_t next_pc;

    modport source (output result, mem_address, store_data, next_pc);
    modport sink   (input result, mem_address, store_data, next_pc);
endinterface

`default_nettype wire

//--- source/tinker_pkg.sv
`default_nettype none

package tinker_pkg;

    // Datapath widths
    localparam int unsigned WORD_W    = 64;
    localparam int unsigned INSTR_W   = 32;
    localparam int unsigned REG_IDX_W = 5;
    localparam int unsigned NUM_REGS  = 32;
    localparam int unsigned LIT_W     = 12;   // Literal field of the instruction word

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // PC step per instruction
    localparam word_t INSTR_BYTES = 64'd4;

    // Tinker opcodes, only the integer subset is implemented
    typedef enum logic [4:0] {
        OP_AND     = 5'h00,
        OP_OR      = 5'h01,
        OP_XOR     = 5'h02,
        OP_NOT     = 5'h03,
        OP_SHFTR   = 5'h04,
        OP_SHFTRI  = 5'h05,
        OP_SHFTL   = 5'h06,
        OP_SHFTLI  = 5'h07,
        OP_BR      = 5'h08,
        OP_BRR     = 5'h09,
        OP_BRRI    = 5'h0A,
        OP_BRNZ    = 5'h0B,
        OP_BRGT    = 5'h0E,
        OP_PRIV    = 5'h0F,  // Halt
        OP_MOV_MEM = 5'h10,  // rd <- mem[rs + L]
        OP_MOV_REG = 5'h11,
        OP_MOV_LIT = 5'h12,  // Low 12 bits of rd replaced
        OP_MOV_STR = 5'h13,  // mem[rd + L] <- rs
        OP_ADD     = 5'h18,
        OP_ADDI    = 5'h19,
        OP_SUB     = 5'h1A,
        OP_SUBI    = 5'h1B,
        OP_MUL     = 5'h1C
    } opcode_t;

    // One cycle per phase, three per instruction
    typedef enum logic [1:0] {
        PH_FETCH   = 2'd0,
        PH_EXECUTE = 2'd1,
        PH_RESULT  = 2'd2
    } phase_t;

endpackage

`default_nettype wire
